// File: list.f
rtl/lpe_pkg.sv
rtl/lpe_operand_buffer.sv
rtl/lpe_mac.sv
rtl/lpe_result_port.sv
rtl/lpe_control_unit.sv
rtl/lpe_top.sv
test/lpe_assertions.sv
test/lpe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the LPE testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module lpe_tb -f list.f -o lpe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/lpe_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: test/lpe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_tb;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_PAIRS = 60;
  localparam int WATCHDOG_NS = NUM_PAIRS * 20 * CLK_PERIOD + 20000;

  logic              clk;
  logic              rst;
  lpe_pkg::operand_t l_data;
  logic              l_last;
  logic              l_valid;
  logic              l_ready;
  lpe_pkg::operand_t u_data;
  logic              u_last;
  logic              u_valid;
  logic              u_ready;
  lpe_pkg::acc_t     d_data;
  logic              d_valid;
  logic              d_ready;
  logic              err_unaligned;

  // Packet beats of both streams and the expected results
  lpe_pkg::operand_t l_data_q[$];
  logic              l_last_q[$];
  lpe_pkg::operand_t u_data_q[$];
  logic              u_last_q[$];
  lpe_pkg::acc_t     exp_q[$];

  integer        seed;
  logic [31:0]   rnd;
  lpe_pkg::acc_t exp_sum;
  logic          started;
  logic          l_fire = 1'b0;
  logic          u_fire = 1'b0;
  logic          stall_seen = 1'b0;
  int            cycle = 0;
  int            l_pos = 0;
  int            u_pos = 0;
  int            errors = 0;
  int            err_exp = 0;
  int            err_seen = 0;
  int            res_seen = 0;

  lpe_top i_lpe_top (
    .clk           (clk),
    .rst           (rst),
    .l_data        (l_data),
    .l_last        (l_last),
    .l_valid       (l_valid),
    .l_ready       (l_ready),
    .u_data        (u_data),
    .u_last        (u_last),
    .u_valid       (u_valid),
    .u_ready       (u_ready),
    .d_data        (d_data),
    .d_valid       (d_valid),
    .d_ready       (d_ready),
    .err_unaligned (err_unaligned)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Builds all packet pairs and the model sums up front
  task automatic build_packets();
    int len_l;
    int len_u;
    int acc;
    for (int p = 0; p < NUM_PAIRS; p++) begin
      rnd = $random(seed);
      len_l = 1 + int'(rnd[2:0]);
      len_u = len_l;
      rnd = $random(seed);
      if (p == 0) begin
        // Single-beat pair first
        len_l = 1;
        len_u = 1;
      end else if (rnd % 6 == 0) begin
        len_u = (len_l % 8) + 1;
      end
      acc = 0;
      for (int j = 0; j < 8; j++) begin
        rnd = $random(seed);
        if (j < len_l) begin
          l_data_q.push_back(rnd[7:0]);
          l_last_q.push_back(j == len_l - 1);
        end
        if (j < len_u) begin
          u_data_q.push_back(rnd[15:8]);
          u_last_q.push_back(j == len_u - 1);
        end
        if (j < len_l && j < len_u) begin
          acc = acc + int'($signed(rnd[7:0])) * int'($signed(rnd[15:8]));
        end
      end
      if (len_l == len_u) begin
        exp_q.push_back(acc[lpe_pkg::ACC_WIDTH-1:0]);
      end else begin
        err_exp = err_exp + 1;
      end
    end
  endtask

  // Handshakes sampled mid-cycle and results checked against the model
  always @(negedge clk) begin
    l_fire = l_valid && l_ready;
    u_fire = u_valid && u_ready;
    if (!rst) begin
      if (!started) begin
        assert (!d_valid && !err_unaligned) else begin
          errors = errors + 1;
          $display("FAILED %0d ns: output active before any input", $time);
        end
      end
      if (err_unaligned) begin
        err_seen = err_seen + 1;
      end
      if (cycle % 200 >= 170 && !l_ready && !u_ready) begin
        stall_seen = 1'b1;
      end
      if (d_valid && d_ready) begin
        res_seen = res_seen + 1;
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("Extra result %0d appeared with no aligned pair pending", d_data);
        end else begin
          exp_sum = exp_q.pop_front();
          assert (d_data == exp_sum) else begin
            errors = errors + 1;
            $display("FAILED %0d ns: result %0d, expected %0d", $time, d_data, exp_sum);
          end
        end
      end
    end
  end

  // Beats held until accepted with random gaps and a d_ready stall every 200 cycles
  always @(posedge clk) begin
    if (started) begin
      rnd = $random(seed);
      cycle = cycle + 1;
      if (l_fire) begin
        l_pos = l_pos + 1;
      end
      if (u_fire) begin
        u_pos = u_pos + 1;
      end
      if (!l_valid || l_fire) begin
        if (l_pos < l_data_q.size() && rnd[1:0] != 2'd0) begin
          l_valid <= 1'b1;
          l_data  <= l_data_q[l_pos];
          l_last  <= l_last_q[l_pos];
        end else begin
          l_valid <= 1'b0;
        end
      end
      if (!u_valid || u_fire) begin
        if (u_pos < u_data_q.size() && rnd[3:2] != 2'd0) begin
          u_valid <= 1'b1;
          u_data  <= u_data_q[u_pos];
          u_last  <= u_last_q[u_pos];
        end else begin
          u_valid <= 1'b0;
        end
      end
      if (cycle % 200 >= 160) begin
        d_ready <= 1'b0;
      end else begin
        d_ready <= rnd[4];
      end
    end
  end

  initial begin
    rst     <= 1'b1;
    started <= 1'b0;
    l_data  <= '0;
    l_last  <= 1'b0;
    l_valid <= 1'b0;
    u_data  <= '0;
    u_last  <= 1'b0;
    u_valid <= 1'b0;
    d_ready <= 1'b0;
    seed = 64647;
    build_packets();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    started <= 1'b1;
    while (l_pos < l_data_q.size() || u_pos < u_data_q.size() || exp_q.size() != 0) begin
      @(posedge clk);
    end
    // Let a trailing flush or stray result show up
    repeat (20) @(posedge clk);
    if (err_seen != err_exp) begin
      errors = errors + 1;
      $display("Saw %0d unaligned error pulses where %0d were expected", err_seen, err_exp);
    end
    if (!stall_seen) begin
      errors = errors + 1;
      $display("Back-pressure never stalled both input streams");
    end
    errors = errors + i_lpe_top.i_lpe_assertions.fail_count;
    $display("Errors: %0d, results: %0d, unaligned pulses: %0d", errors, res_seen, err_seen);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, %0d results still missing", WATCHDOG_NS, exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/lpe_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_assertions (
  input wire                clk,
  input wire                rst,
  input wire                d_valid,
  input wire                d_ready,
  input wire lpe_pkg::acc_t d_data,
  input wire                err_unaligned,
  input wire                l_pop,
  input wire                u_pop,
  input wire                l_drop,
  input wire                u_drop,
  input wire                mac_start,
  input wire                mac_step,
  input wire                mac_clear,
  input wire                push
);

  int fail_count = 0;

  // Down beat held under back-pressure
  hold_result: assert property (@(posedge clk) disable iff (rst)
    d_valid && !d_ready |=> d_valid && $stable(d_data))
    else begin
      fail_count++;
      $error("down stream beat changed while d_ready was low");
    end

  single_err_pulse: assert property (@(posedge clk) disable iff (rst)
    err_unaligned |=> !err_unaligned)
    else begin
      fail_count++;
      $error("err_unaligned high for two cycles in a row");
    end

  // Quiet control right after reset
  idle_after_reset: assert property (@(posedge clk)
    $past(rst) && !rst |-> !(l_pop || u_pop || l_drop || u_drop || mac_start ||
                             mac_step || mac_clear || push || err_unaligned))
    else begin
      fail_count++;
      $error("control output active in the first cycle after reset");
    end

endmodule

bind lpe_top lpe_assertions i_lpe_assertions (
  .clk           (clk),
  .rst           (rst),
  .d_valid       (d_valid),
  .d_ready       (d_ready),
  .d_data        (d_data),
  .err_unaligned (err_unaligned),
  .l_pop         (l_pop),
  .u_pop         (u_pop),
  .l_drop        (l_drop),
  .u_drop        (u_drop),
  .mac_start     (mac_start),
  .mac_step      (mac_step),
  .mac_clear     (mac_clear),
  .push          (push)
);

`default_nettype wire

// File: rtl/lpe_top.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_top (
  input  wire                clk,
  input  wire                rst,

  // Left stream
  input  wire lpe_pkg::operand_t l_data,
  input  wire                l_last,
  input  wire                l_valid,
  output logic               l_ready,

  // Up stream
  input  wire lpe_pkg::operand_t u_data,
  input  wire                u_last,
  input  wire                u_valid,
  output logic               u_ready,

  // Down stream
  output lpe_pkg::acc_t      d_data,
  output logic               d_valid,
  input  wire                d_ready,

  output logic               err_unaligned
);

  lpe_pkg::operand_t l_buf_data;
  lpe_pkg::operand_t u_buf_data;
  lpe_pkg::acc_t     sum;

  logic l_full;
  logic l_buf_last;
  logic l_pop;
  logic l_drop;
  logic u_full;
  logic u_buf_last;
  logic u_pop;
  logic u_drop;
  logic mac_start;
  logic mac_step;
  logic mac_clear;
  logic push;
  logic res_full;

  lpe_operand_buffer i_left_buf (
    .clk      (clk),
    .rst      (rst),
    .in_data  (l_data),
    .in_last  (l_last),
    .in_valid (l_valid),
    .in_ready (l_ready),
    .pop      (l_pop),
    .drop     (l_drop),
    .full     (l_full),
    .data     (l_buf_data),
    .last     (l_buf_last)
  );

  lpe_operand_buffer i_up_buf (
    .clk      (clk),
    .rst      (rst),
    .in_data  (u_data),
    .in_last  (u_last),
    .in_valid (u_valid),
    .in_ready (u_ready),
    .pop      (u_pop),
    .drop     (u_drop),
    .full     (u_full),
    .data     (u_buf_data),
    .last     (u_buf_last)
  );

  lpe_mac i_mac (
    .clk       (clk),
    .rst       (rst),
    .a         (l_buf_data),
    .b         (u_buf_data),
    .mac_start (mac_start),
    .mac_step  (mac_step),
    .mac_clear (mac_clear),
    .sum       (sum)
  );

  lpe_result_port i_result_port (
    .clk     (clk),
    .rst     (rst),
    .sum     (sum),
    .push    (push),
    .full    (res_full),
    .d_data  (d_data),
    .d_valid (d_valid),
    .d_ready (d_ready)
  );

  lpe_control_unit i_control_unit (
    .clk           (clk),
    .rst           (rst),
    .l_full        (l_full),
    .l_last        (l_buf_last),
    .u_full        (u_full),
    .u_last        (u_buf_last),
    .res_full      (res_full),
    .l_pop         (l_pop),
    .u_pop         (u_pop),
    .l_drop        (l_drop),
    .u_drop        (u_drop),
    .mac_start     (mac_start),
    .mac_step      (mac_step),
    .mac_clear     (mac_clear),
    .push          (push),
    .err_unaligned (err_unaligned)
  );

endmodule

`default_nettype wire

// File: rtl/lpe_control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_control_unit (
  input  wire  clk,
  input  wire  rst,

  // Buffer and result port status
  input  wire  l_full,
  input  wire  l_last,
  input  wire  u_full,
  input  wire  u_last,
  input  wire  res_full,

  // Buffer commands
  output logic l_pop,
  output logic u_pop,
  output logic l_drop,
  output logic u_drop,

  // Accumulator commands
  output logic mac_start,
  output logic mac_step,
  output logic mac_clear,

  output logic push,
  output logic err_unaligned
);

  lpe_pkg::lpe_state_t state;
  lpe_pkg::lpe_state_t state_next;

  logic first;
  logic first_next;
  // Last beat of the stream already dropped during a flush
  logic l_done;
  logic l_done_next;
  logic u_done;
  logic u_done_next;

  logic push_next;
  logic err_next;
  logic pair;

  assign pair = l_full && u_full;

  always_comb begin
    state_next  = state;
    first_next  = first;
    l_done_next = l_done;
    u_done_next = u_done;
    push_next   = 1'b0;
    err_next    = 1'b0;
    l_pop       = 1'b0;
    u_pop       = 1'b0;
    l_drop      = 1'b0;
    u_drop      = 1'b0;
    mac_start   = 1'b0;
    mac_step    = 1'b0;
    mac_clear   = 1'b0;

    case (state)
      lpe_pkg::ST_START, lpe_pkg::ST_MAC: begin
        if (pair) begin
          l_pop = 1'b1;
          u_pop = 1'b1;
          if (l_last != u_last) begin
            // Unaligned pair, drop the partial sum and flush the longer packet
            mac_clear   = 1'b1;
            err_next    = 1'b1;
            first_next  = 1'b1;
            l_done_next = l_last;
            u_done_next = u_last;
            state_next  = lpe_pkg::ST_FLUSH;
          end else begin
            mac_step   = 1'b1;
            mac_start  = first;
            first_next = l_last;
            if (l_last) begin
              state_next = lpe_pkg::ST_END;
            end else begin
              state_next = lpe_pkg::ST_MAC;
            end
          end
        end
      end

      lpe_pkg::ST_END: begin
        // Wait here while the previous result is still pending
        if (!res_full) begin
          push_next  = 1'b1;
          state_next = lpe_pkg::ST_START;
        end
      end

      lpe_pkg::ST_FLUSH: begin
        l_drop = l_full && !l_done;
        u_drop = u_full && !u_done;
        if (l_drop && l_last) begin
          l_done_next = 1'b1;
        end
        if (u_drop && u_last) begin
          u_done_next = 1'b1;
        end
        if (l_done_next && u_done_next) begin
          state_next = lpe_pkg::ST_START;
        end
      end

      default: begin
        first_next = 1'b1;
        state_next = lpe_pkg::ST_START;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= lpe_pkg::ST_START;
      first         <= 1'b1;
      l_done        <= 1'b0;
      u_done        <= 1'b0;
      push          <= 1'b0;
      err_unaligned <= 1'b0;
    end else begin
      state         <= state_next;
      first         <= first_next;
      l_done        <= l_done_next;
      u_done        <= u_done_next;
      push          <= push_next;
      err_unaligned <= err_next;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpe_result_port.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_result_port (
  input  wire               clk,
  input  wire               rst,

  // Finished sum from the accumulator
  input  wire lpe_pkg::acc_t sum,
  input  wire               push,
  output logic              full,

  // Down stream
  output lpe_pkg::acc_t     d_data,
  output logic              d_valid,
  input  wire               d_ready
);

  logic occupied;
  logic load;

  assign load    = push && !occupied;
  assign full    = occupied;
  assign d_valid = occupied;

  always_ff @(posedge clk) begin
    if (rst) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= 1'b1;
    end else if (occupied && d_ready) begin
      // Entry released on the down handshake
      occupied <= 1'b0;
    end
  end

  // Held stable while d_valid is high
  always_ff @(posedge clk) begin
    if (load) begin
      d_data <= sum;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpe_mac.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_mac (
  input  wire               clk,
  input  wire               rst,

  // Operand pair
  input  wire lpe_pkg::operand_t a,
  input  wire lpe_pkg::operand_t b,

  // Commands
  input  wire               mac_start,
  input  wire               mac_step,
  input  wire               mac_clear,

  output lpe_pkg::acc_t     sum
);

  logic signed [2*lpe_pkg::OPERAND_WIDTH-1:0] product;
  lpe_pkg::acc_t                              product_ext;

  assign product = $signed(a) * $signed(b);

  // Sign extend the product to the accumulator width
  assign product_ext = {
    {(lpe_pkg::ACC_WIDTH - 2*lpe_pkg::OPERAND_WIDTH){product[2*lpe_pkg::OPERAND_WIDTH-1]}},
    product
  };

  always_ff @(posedge clk) begin
    if (rst || mac_clear) begin
      sum <= '0;
    end else if (mac_step) begin
      if (mac_start) begin
        // First pair of a packet replaces the old sum
        sum <= product_ext;
      end else begin
        sum <= sum + product_ext;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpe_operand_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module lpe_operand_buffer (
  input  wire               clk,
  input  wire               rst,

  // Incoming stream
  input  wire lpe_pkg::operand_t in_data,
  input  wire               in_last,
  input  wire               in_valid,
  output logic              in_ready,

  // Commands from the control unit
  input  wire               pop,
  input  wire               drop,

  // Held beat
  output logic              full,
  output lpe_pkg::operand_t data,
  output logic              last
);

  logic accept;

  // Free slot, or the held beat leaves in this cycle
  assign in_ready = !full || pop || drop;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (pop || drop) begin
      full <= 1'b0;
    end
  end

  // Payload follows the accepted beat
  always_ff @(posedge clk) begin
    if (accept) begin
      data <= in_data;
      last <= in_last;
    end
  end

endmodule

`default_nettype wire

// File: rtl/lpe_pkg.sv
`default_nettype none

package lpe_pkg;

  // Operand width of both input streams
  localparam int OPERAND_WIDTH = 8;

  // Accumulator width, the sum wraps modulo 2**ACC_WIDTH
  localparam int ACC_WIDTH = 24;

  // One signed operand, left or up stream
  typedef logic [OPERAND_WIDTH-1:0] operand_t;

  // Signed running sum and finished result
  typedef logic [ACC_WIDTH-1:0] acc_t;

  // Control unit states
  typedef enum logic [1:0] {
    // Waiting for the first pair of a packet
    ST_START = 2'd0,
    // Accumulating middle pairs
    ST_MAC   = 2'd1,
    // Handing the result to the down port
    ST_END   = 2'd2,
    // Discarding the tail of a packet after an error
    ST_FLUSH = 2'd3
  } lpe_state_t;

endpackage

`default_nettype wire
